// File: logic/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

    // --------------------
    // sizes and constants
    // --------------------

    // reorder buffer depth, sets the rob index width
    localparam int ROB_SIZE = 32;
    // data memory depth in words
    localparam int MEM_WORDS = 64;
    // every memory word starts as its index plus this key
    localparam logic [31:0] MEM_INIT_KEY = 32'h5A000000;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [$clog2(ROB_SIZE)-1:0] rob_idx_t;
    // wide enough for any load queue up to 256 entries
    typedef logic [7:0] tag_t;

    // --------------------
    // queue entries
    // --------------------

    // one load queue slot
    typedef struct packed {
        logic     valid;
        logic     issued;
        logic     data_valid;
        addr_t    addr;
        rob_idx_t rob_idx;
        word_t    data;
    } lq_entry_t;

    // what the load queue sees of each store slot
    typedef struct packed {
        logic     valid;
        logic     addr_valid;
        rob_idx_t rob_idx;
    } sq_view_t;

    // --------------------
    // memory traffic
    // --------------------

    typedef struct packed {
        addr_t addr;
        tag_t  tag;
    } mem_req_t;

    typedef struct packed {
        word_t data;
        tag_t  tag;
    } mem_rsp_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        word_t data;
    } store_write_t;

    // age compare against the rob head
    // distance wraps mod ROB_SIZE through the index width
    function automatic logic is_older(input rob_idx_t a, input rob_idx_t b,
                                      input rob_idx_t head);
        rob_idx_t dist_a;
        rob_idx_t dist_b;
        dist_a = a - head;
        dist_b = b - head;
        return dist_a < dist_b;
    endfunction

endpackage

`default_nettype wire

// File: logic/store_queue.sv
`default_nettype none

module store_queue #(
    parameter int SQ_SIZE = 8
) (
    input  wire logic                   clock,
    input  wire logic                   reset,
    // dispatch, address still unknown
    input  wire logic                   enq_i,
    input  wire lsq_pkg::rob_idx_t      enq_rob_idx_i,
    input  wire lsq_pkg::word_t         enq_data_i,
    output logic                        full_o,
    // late address fill by slot
    input  wire logic                   addr_valid_i,
    input  wire [$clog2(SQ_SIZE)-1:0]   addr_idx_i,
    input  wire lsq_pkg::addr_t         addr_i,
    // commit frees the head
    input  wire logic                   commit_i,
    input  wire lsq_pkg::rob_idx_t      rob_head_i,
    // forwarding query from the load queue
    input  wire logic                   query_valid_i,
    input  wire lsq_pkg::addr_t         query_addr_i,
    input  wire lsq_pkg::rob_idx_t      query_rob_idx_i,
    output logic                        fwd_valid_o,
    output lsq_pkg::word_t              fwd_data_o,
    output lsq_pkg::sq_view_t           view_o [SQ_SIZE],
    output lsq_pkg::store_write_t       store_write_o
);
    import lsq_pkg::*;

    localparam int IDX_W = $clog2(SQ_SIZE);

    sq_view_t               ctrl [SQ_SIZE];
    addr_t                  st_addr [SQ_SIZE];
    word_t                  st_data [SQ_SIZE];
    logic [IDX_W-1:0]       head;
    logic [IDX_W-1:0]       tail;
    logic [$clog2(SQ_SIZE+1)-1:0] count;
    logic [IDX_W-1:0]       best;
    logic                   do_enq;
    logic                   do_commit;

    function automatic logic [IDX_W-1:0] next_ptr(input logic [IDX_W-1:0] ptr);
        return (ptr == IDX_W'(SQ_SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o    = (count == SQ_SIZE);
    assign do_enq    = enq_i && !full_o;
    assign do_commit = commit_i && (count != 0);
    assign view_o    = ctrl;

    // --------------------
    // forwarding search
    // --------------------

    // youngest store older than the load with a known matching word
    always_comb begin
        fwd_valid_o = 1'b0;
        best        = '0;
        for (int i = 0; i < SQ_SIZE; i++) begin
            if (query_valid_i && ctrl[i].valid && ctrl[i].addr_valid
                    && (st_addr[i][31:2] == query_addr_i[31:2])
                    && is_older(ctrl[i].rob_idx, query_rob_idx_i, rob_head_i)) begin
                if (!fwd_valid_o || is_older(ctrl[best].rob_idx, ctrl[i].rob_idx, rob_head_i)) begin
                    fwd_valid_o = 1'b1;
                    best        = IDX_W'(i);
                end
            end
        end
    end

    assign fwd_data_o = st_data[best];

    // memory takes the head store at the same edge it leaves the queue
    always_comb begin
        store_write_o.valid = do_commit && ctrl[head].valid && ctrl[head].addr_valid;
        store_write_o.addr  = st_addr[head];
        store_write_o.data  = st_data[head];
    end

    // --------------------
    // state update
    // --------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < SQ_SIZE; i++) begin
                ctrl[i].valid      <= 1'b0;
                ctrl[i].addr_valid <= 1'b0;
            end
        end else begin
            if (do_enq) begin
                ctrl[tail].valid      <= 1'b1;
                ctrl[tail].addr_valid <= 1'b0;
                ctrl[tail].rob_idx    <= enq_rob_idx_i;
                st_data[tail]         <= enq_data_i;
                tail                  <= next_ptr(tail);
            end
            if (addr_valid_i) begin
                ctrl[addr_idx_i].addr_valid <= 1'b1;
                st_addr[addr_idx_i]         <= addr_i;
            end
            if (do_commit) begin
                ctrl[head].valid <= 1'b0;
                head             <= next_ptr(head);
            end
            case ({do_enq, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/load_queue.sv
`default_nettype none

module load_queue #(
    parameter int LQ_SIZE = 8,
    parameter int SQ_SIZE = 8
) (
    input  wire logic              clock,
    input  wire logic              reset,
    // dispatch
    input  wire logic              enq_i,
    input  wire lsq_pkg::addr_t    enq_addr_i,
    input  wire lsq_pkg::rob_idx_t enq_rob_idx_i,
    output logic                   full_o,
    output logic                   empty_o,
    // age reference and store queue view
    input  wire lsq_pkg::rob_idx_t rob_head_i,
    input  wire lsq_pkg::sq_view_t sq_view_i [SQ_SIZE],
    // store forwarding query
    input  wire logic              fwd_valid_i,
    input  wire lsq_pkg::word_t    fwd_data_i,
    output logic                   query_valid_o,
    output lsq_pkg::addr_t         query_addr_o,
    output lsq_pkg::rob_idx_t      query_rob_idx_o,
    // memory request and response
    output logic                   mem_req_valid_o,
    output lsq_pkg::mem_req_t      mem_req_o,
    input  wire logic              mem_req_accept_i,
    input  wire logic              mem_rsp_valid_i,
    input  wire lsq_pkg::mem_rsp_t mem_rsp_i,
    // commit from the rob
    input  wire logic              commit_valid_i,
    input  wire lsq_pkg::rob_idx_t commit_idx_i,
    // writeback pulse
    output logic                   wb_valid_o,
    output lsq_pkg::rob_idx_t      wb_rob_idx_o,
    output lsq_pkg::word_t         wb_data_o
);
    import lsq_pkg::*;

    localparam int IDX_W = $clog2(LQ_SIZE);

    lq_entry_t              lq [LQ_SIZE];
    logic [IDX_W-1:0]       head;
    logic [IDX_W-1:0]       tail;
    logic [$clog2(LQ_SIZE+1)-1:0] count;

    logic                   found;
    logic [IDX_W-1:0]       cand_idx;
    lq_entry_t              cand;
    logic                   stall;
    logic                   do_enq;
    logic                   do_commit;
    logic                   fwd_take;
    logic [IDX_W-1:0]       rsp_idx;

    // circular increment, fine for any queue size
    function automatic logic [IDX_W-1:0] next_ptr(input logic [IDX_W-1:0] ptr);
        return (ptr == IDX_W'(LQ_SIZE - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = (count == LQ_SIZE);
    assign empty_o = (count == 0);

    // --------------------
    // candidate search
    // --------------------

    // oldest entry with no data that has not gone to memory yet
    always_comb begin
        int idx;
        found    = 1'b0;
        cand_idx = '0;
        for (int i = 0; i < LQ_SIZE; i++) begin
            idx = int'(head) + i;
            if (idx >= LQ_SIZE) begin
                idx = idx - LQ_SIZE;
            end
            if (!found && lq[idx].valid && !lq[idx].issued && !lq[idx].data_valid) begin
                found    = 1'b1;
                cand_idx = IDX_W'(idx);
            end
        end
    end

    assign cand = lq[cand_idx];

    // hold the candidate while an older store has no address yet
    always_comb begin
        stall = 1'b0;
        for (int k = 0; k < SQ_SIZE; k++) begin
            if (sq_view_i[k].valid && !sq_view_i[k].addr_valid
                    && is_older(sq_view_i[k].rob_idx, cand.rob_idx, rob_head_i)) begin
                stall = 1'b1;
            end
        end
    end

    // query only goes out once the age check is clear
    assign query_valid_o   = found && !stall;
    assign query_addr_o    = cand.addr;
    assign query_rob_idx_o = cand.rob_idx;

    // forwarded data beats the memory, so no request on a hit
    assign mem_req_valid_o = query_valid_o && !fwd_valid_i;

    always_comb begin
        mem_req_o.addr             = cand.addr;
        mem_req_o.tag              = '0;
        mem_req_o.tag[IDX_W-1:0]   = cand_idx;
    end

    assign do_enq    = enq_i && !full_o;
    assign do_commit = commit_valid_i && !empty_o && lq[head].valid
                       && (commit_idx_i == lq[head].rob_idx);
    // writeback port is busy when the memory answers
    assign fwd_take  = query_valid_o && fwd_valid_i && !mem_rsp_valid_i;
    assign rsp_idx   = mem_rsp_i.tag[IDX_W-1:0];

    // --------------------
    // state update
    // --------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            wb_valid_o <= 1'b0;
            for (int i = 0; i < LQ_SIZE; i++) begin
                lq[i].valid      <= 1'b0;
                lq[i].issued     <= 1'b0;
                lq[i].data_valid <= 1'b0;
            end
        end else begin
            // single cycle pulse by default
            wb_valid_o <= 1'b0;

            if (do_enq) begin
                lq[tail].valid      <= 1'b1;
                lq[tail].issued     <= 1'b0;
                lq[tail].data_valid <= 1'b0;
                lq[tail].addr       <= enq_addr_i;
                lq[tail].rob_idx    <= enq_rob_idx_i;
                tail                <= next_ptr(tail);
            end

            // request taken by the memory
            if (mem_req_valid_o && mem_req_accept_i) begin
                lq[cand_idx].issued <= 1'b1;
            end

            // memory response lands by tag, forward capture otherwise
            if (mem_rsp_valid_i) begin
                lq[rsp_idx].data       <= mem_rsp_i.data;
                lq[rsp_idx].data_valid <= 1'b1;
                wb_valid_o             <= 1'b1;
                wb_rob_idx_o           <= lq[rsp_idx].rob_idx;
                wb_data_o              <= mem_rsp_i.data;
            end else if (fwd_take) begin
                lq[cand_idx].data       <= fwd_data_i;
                lq[cand_idx].data_valid <= 1'b1;
                wb_valid_o              <= 1'b1;
                wb_rob_idx_o            <= cand.rob_idx;
                wb_data_o               <= fwd_data_i;
            end

            // free the head only on a matching rob index
            if (do_commit) begin
                lq[head].valid <= 1'b0;
                head           <= next_ptr(head);
            end

            case ({do_enq, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/data_memory.sv
`default_nettype none

module data_memory #(
    parameter int MEM_LATENCY = 2
) (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  req_valid_i,
    input  wire lsq_pkg::mem_req_t     req_i,
    output logic                       req_accept_o,
    output logic                       rsp_valid_o,
    output lsq_pkg::mem_rsp_t          rsp_o,
    input  wire lsq_pkg::store_write_t store_write_i
);
    import lsq_pkg::*;

    localparam int WIDX_W = $clog2(MEM_WORDS);

    word_t                  mem [MEM_WORDS];
    logic [MEM_LATENCY-1:0] pipe_valid;
    mem_rsp_t               pipe_rsp [MEM_LATENCY];

    // one port, a store write takes it for the cycle
    assign req_accept_o = !store_write_i.valid;

    // contents rule, and commit writes by word index
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= word_t'(i) + MEM_INIT_KEY;
            end
        end else if (store_write_i.valid) begin
            mem[store_write_i.addr[WIDX_W+1:2]] <= store_write_i.data;
        end
    end

    // read pipeline, data sampled when the request is accepted
    always_ff @(posedge clock) begin
        if (reset) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid[0] <= req_valid_i && req_accept_o;
            for (int s = 1; s < MEM_LATENCY; s++) begin
                pipe_valid[s] <= pipe_valid[s-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        pipe_rsp[0].data <= mem[req_i.addr[WIDX_W+1:2]];
        pipe_rsp[0].tag  <= req_i.tag;
        for (int s = 1; s < MEM_LATENCY; s++) begin
            pipe_rsp[s] <= pipe_rsp[s-1];
        end
    end

    assign rsp_valid_o = pipe_valid[MEM_LATENCY-1];
    assign rsp_o       = pipe_rsp[MEM_LATENCY-1];

endmodule

`default_nettype wire

// File: logic/lsq_top.sv
`default_nettype none

module lsq_top #(
    parameter int LQ_SIZE     = 8,
    parameter int SQ_SIZE     = 8,
    parameter int MEM_LATENCY = 2
) (
    input  wire logic                 clock,
    input  wire logic                 reset,
    // loads
    input  wire logic                 ld_enq_i,
    input  wire lsq_pkg::addr_t       ld_addr_i,
    input  wire lsq_pkg::rob_idx_t    ld_rob_idx_i,
    output logic                      lq_full_o,
    output logic                      lq_empty_o,
    // stores
    input  wire logic                 st_enq_i,
    input  wire lsq_pkg::rob_idx_t    st_rob_idx_i,
    input  wire lsq_pkg::word_t       st_data_i,
    input  wire logic                 st_addr_valid_i,
    input  wire [$clog2(SQ_SIZE)-1:0] st_addr_idx_i,
    input  wire lsq_pkg::addr_t       st_addr_i,
    input  wire logic                 st_commit_i,
    output logic                      sq_full_o,
    // rob
    input  wire lsq_pkg::rob_idx_t    rob_head_i,
    input  wire logic                 rob_commit_valid_i,
    input  wire lsq_pkg::rob_idx_t    rob_commit_idx_i,
    // writeback
    output logic                      wb_valid_o,
    output lsq_pkg::rob_idx_t         wb_rob_idx_o,
    output lsq_pkg::word_t            wb_data_o
);
    import lsq_pkg::*;

    // load queue to store queue
    sq_view_t     sq_view [SQ_SIZE];
    logic         query_valid;
    addr_t        query_addr;
    rob_idx_t     query_rob_idx;
    logic         fwd_valid;
    word_t        fwd_data;
    // memory traffic
    logic         mem_req_valid;
    mem_req_t     mem_req;
    logic         mem_req_accept;
    logic         mem_rsp_valid;
    mem_rsp_t     mem_rsp;
    store_write_t store_write;

    load_queue #(
        .LQ_SIZE(LQ_SIZE),
        .SQ_SIZE(SQ_SIZE)
    ) u_load_queue (
        .clock           (clock),
        .reset           (reset),
        .enq_i           (ld_enq_i),
        .enq_addr_i      (ld_addr_i),
        .enq_rob_idx_i   (ld_rob_idx_i),
        .full_o          (lq_full_o),
        .empty_o         (lq_empty_o),
        .rob_head_i      (rob_head_i),
        .sq_view_i       (sq_view),
        .fwd_valid_i     (fwd_valid),
        .fwd_data_i      (fwd_data),
        .query_valid_o   (query_valid),
        .query_addr_o    (query_addr),
        .query_rob_idx_o (query_rob_idx),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_o       (mem_req),
        .mem_req_accept_i(mem_req_accept),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_i       (mem_rsp),
        .commit_valid_i  (rob_commit_valid_i),
        .commit_idx_i    (rob_commit_idx_i),
        .wb_valid_o      (wb_valid_o),
        .wb_rob_idx_o    (wb_rob_idx_o),
        .wb_data_o       (wb_data_o)
    );

    store_queue #(
        .SQ_SIZE(SQ_SIZE)
    ) u_store_queue (
        .clock          (clock),
        .reset          (reset),
        .enq_i          (st_enq_i),
        .enq_rob_idx_i  (st_rob_idx_i),
        .enq_data_i     (st_data_i),
        .full_o         (sq_full_o),
        .addr_valid_i   (st_addr_valid_i),
        .addr_idx_i     (st_addr_idx_i),
        .addr_i         (st_addr_i),
        .commit_i       (st_commit_i),
        .rob_head_i     (rob_head_i),
        .query_valid_i  (query_valid),
        .query_addr_i   (query_addr),
        .query_rob_idx_i(query_rob_idx),
        .fwd_valid_o    (fwd_valid),
        .fwd_data_o     (fwd_data),
        .view_o         (sq_view),
        .store_write_o  (store_write)
    );

    data_memory #(
        .MEM_LATENCY(MEM_LATENCY)
    ) u_data_memory (
        .clock        (clock),
        .reset        (reset),
        .req_valid_i  (mem_req_valid),
        .req_i        (mem_req),
        .req_accept_o (mem_req_accept),
        .rsp_valid_o  (mem_rsp_valid),
        .rsp_o        (mem_rsp),
        .store_write_i(store_write)
    );

endmodule

`default_nettype wire

// File: verif/lsq_tb.sv
`default_nettype none

module lsq_tb;
    import lsq_pkg::*;

    localparam int LQ_SIZE     = 8;
    localparam int SQ_SIZE     = 8;
    localparam int MEM_LATENCY = 2;
    // random operations after the directed fill
    localparam int NUM_OPS     = 300;
    localparam int TOTAL_OPS   = NUM_OPS + LQ_SIZE + 1;
    localparam int CYCLE_LIMIT = 20 * TOTAL_OPS + 200;
    // few words so loads and stores collide often
    localparam int ADDR_WORDS  = 8;
    localparam logic [31:0] INIT_KEY = 32'h5A000000;
    localparam int SQ_IDX_W    = $clog2(SQ_SIZE);

    typedef logic [SQ_IDX_W-1:0] sq_slot_t;

    // one in-flight instruction, kept in program order
    typedef struct packed {
        logic     is_store;
        logic     done;     // load written back or store address filled
        rob_idx_t rob;
        sq_slot_t slot;
        addr_t    addr;
        word_t    data;     // expected value for a load or data of a store
    } op_t;

    logic     clock;
    logic     reset;
    logic     ld_enq;
    addr_t    ld_addr;
    rob_idx_t ld_rob_idx;
    logic     lq_full;
    logic     lq_empty;
    logic     st_enq;
    rob_idx_t st_rob_idx;
    word_t    st_data;
    logic     st_addr_valid;
    sq_slot_t st_addr_idx;
    addr_t    st_addr;
    logic     st_commit;
    logic     sq_full;
    rob_idx_t rob_head;
    logic     rob_commit_valid;
    rob_idx_t rob_commit_idx;
    logic     wb_valid;
    rob_idx_t wb_rob_idx;
    word_t    wb_data;

    // reference model state
    op_t      rob_q [$];
    word_t    spec_mem [ADDR_WORDS];
    int       lq_cnt;
    int       sq_cnt;
    int       lq_occ;
    int       sq_occ;
    int       sq_tail;
    rob_idx_t next_rob;
    integer   seed;
    int       error_count;
    int       check_count;
    int       cycle_count;
    int       issued_ops;

    lsq_top #(
        .LQ_SIZE    (LQ_SIZE),
        .SQ_SIZE    (SQ_SIZE),
        .MEM_LATENCY(MEM_LATENCY)
    ) UUT (
        .clock             (clock),
        .reset             (reset),
        .ld_enq_i          (ld_enq),
        .ld_addr_i         (ld_addr),
        .ld_rob_idx_i      (ld_rob_idx),
        .lq_full_o         (lq_full),
        .lq_empty_o        (lq_empty),
        .st_enq_i          (st_enq),
        .st_rob_idx_i      (st_rob_idx),
        .st_data_i         (st_data),
        .st_addr_valid_i   (st_addr_valid),
        .st_addr_idx_i     (st_addr_idx),
        .st_addr_i         (st_addr),
        .st_commit_i       (st_commit),
        .sq_full_o         (sq_full),
        .rob_head_i        (rob_head),
        .rob_commit_valid_i(rob_commit_valid),
        .rob_commit_idx_i  (rob_commit_idx),
        .wb_valid_o        (wb_valid),
        .wb_rob_idx_o      (wb_rob_idx),
        .wb_data_o         (wb_data)
    );

    always #10 clock = ~clock;

    // run limit
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // byte address of a word plus an offset the design ignores
    function automatic addr_t byte_addr(input int w, input int offset);
        return addr_t'(w * 4 + offset);
    endfunction

    // --------------------
    // checks
    // --------------------

    task automatic check_flags();
        check_count++;
        assert (lq_full == (lq_cnt == LQ_SIZE) && lq_empty == (lq_cnt == 0)) else begin
            error_count++;
            $display("ERR flags: expected full %0b empty %0b, actual full %0b empty %0b",
                     lq_cnt == LQ_SIZE, lq_cnt == 0, lq_full, lq_empty);
        end
        check_count++;
        assert (sq_full == (sq_cnt == SQ_SIZE)) else begin
            error_count++;
            $display("ERR sq full: expected %0b, actual %0b", sq_cnt == SQ_SIZE, sq_full);
        end
    endtask

    // match the pulse to any waiting load in any order
    task automatic check_writeback();
        op_t  op;
        int   pos;
        logic unfilled;
        pos      = -1;
        unfilled = 1'b0;
        if (wb_valid) begin
            for (int i = 0; i < rob_q.size(); i++) begin
                if (pos < 0 && rob_q[i].is_store && !rob_q[i].done) begin
                    unfilled = 1'b1;
                end
                if (pos < 0 && !rob_q[i].is_store && !rob_q[i].done
                        && rob_q[i].rob == wb_rob_idx) begin
                    pos = i;
                end
            end
            check_count++;
            assert (pos >= 0) else begin
                error_count++;
                $display("writeback for rob index %0d matches no waiting load", wb_rob_idx);
            end
            if (pos >= 0) begin
                op = rob_q[pos];
                assert (wb_data == op.data) else begin
                    error_count++;
                    $display("ERR writeback rob %0d: expected %h, actual %h",
                             op.rob, op.data, wb_data);
                end
                // an older store with no address must hold the load
                assert (!unfilled) else begin
                    error_count++;
                    $display("load %0d wrote back before an older store address was known",
                             op.rob);
                end
                op.done    = 1'b1;
                rob_q[pos] = op;
            end
        end
    endtask

    // check at the falling edge and then clear the strobes
    task automatic next_cycle();
        @(negedge clock);
        check_writeback();
        check_flags();
        lq_occ           = lq_cnt;
        sq_occ           = sq_cnt;
        ld_enq           = 1'b0;
        st_enq           = 1'b0;
        st_addr_valid    = 1'b0;
        st_commit        = 1'b0;
        rob_commit_valid = 1'b0;
        // oldest instruction still in flight
        rob_head = (rob_q.size() > 0) ? rob_q[0].rob : next_rob;
    endtask

    // --------------------
    // stimulus
    // --------------------

    // a load sees the youngest older store to its word or else memory
    task automatic dispatch_load();
        op_t op;
        int  w;
        w          = $unsigned($random(seed)) % ADDR_WORDS;
        ld_enq     = 1'b1;
        ld_addr    = byte_addr(w, $unsigned($random(seed)) % 4);
        ld_rob_idx = next_rob;
        // a full queue drops it
        if (lq_occ < LQ_SIZE) begin
            op      = '0;
            op.rob  = next_rob;
            op.addr = ld_addr;
            op.data = spec_mem[w];
            rob_q.push_back(op);
            lq_cnt++;
        end
        next_rob++;
    endtask

    task automatic dispatch_store();
        op_t op;
        int  w;
        w           = $unsigned($random(seed)) % ADDR_WORDS;
        op          = '0;
        op.is_store = 1'b1;
        op.rob      = next_rob;
        op.slot     = sq_slot_t'(sq_tail);
        op.addr     = byte_addr(w, $unsigned($random(seed)) % 4);
        op.data     = $random(seed);
        st_enq      = 1'b1;
        st_rob_idx  = next_rob;
        st_data     = op.data;
        rob_q.push_back(op);
        spec_mem[w] = op.data;
        sq_cnt++;
        sq_tail     = (sq_tail + 1) % SQ_SIZE;
        next_rob++;
    endtask

    // retire the head when ready or send an index nobody holds
    task automatic commit_head();
        op_t op;
        if (rob_q.size() > 0 && ($random(seed) & 3) != 0) begin
            op = rob_q[0];
            if (op.done && op.is_store) begin
                st_commit = 1'b1;
                sq_cnt--;
                op = rob_q.pop_front();
            end else if (op.done) begin
                rob_commit_valid = 1'b1;
                rob_commit_idx   = op.rob;
                lq_cnt--;
                op = rob_q.pop_front();
            end
        end else begin
            rob_commit_valid = 1'b1;
            rob_commit_idx   = next_rob + rob_idx_t'(8);
        end
    endtask

    task automatic fill_random_store();
        op_t op;
        int  j;
        if (rob_q.size() > 0 && ($random(seed) & 1) != 0) begin
            j  = $unsigned($random(seed)) % rob_q.size();
            op = rob_q[j];
            if (op.is_store && !op.done) begin
                st_addr_valid = 1'b1;
                st_addr_idx   = op.slot;
                st_addr       = op.addr;
                op.done       = 1'b1;
                rob_q[j]      = op;
            end
        end
    endtask

    task automatic random_dispatch();
        int pick;
        pick = $unsigned($random(seed)) % 4;
        if ((pick == 1 || pick == 3) && lq_occ < LQ_SIZE) begin
            dispatch_load();
            issued_ops++;
        end else if (pick == 2 && sq_occ < SQ_SIZE) begin
            dispatch_store();
            issued_ops++;
        end
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        seed             = 32'h704;
        error_count      = 0;
        check_count      = 0;
        cycle_count      = 0;
        issued_ops       = 0;
        lq_cnt           = 0;
        sq_cnt           = 0;
        lq_occ           = 0;
        sq_occ           = 0;
        sq_tail          = 0;
        next_rob         = '0;
        clock            = 1'b0;
        reset            = 1'b1;
        ld_enq           = 1'b0;
        ld_addr          = '0;
        ld_rob_idx       = '0;
        st_enq           = 1'b0;
        st_rob_idx       = '0;
        st_data          = '0;
        st_addr_valid    = 1'b0;
        st_addr_idx      = '0;
        st_addr          = '0;
        st_commit        = 1'b0;
        rob_head         = '0;
        rob_commit_valid = 1'b0;
        rob_commit_idx   = '0;
        // memory contents rule
        for (int w = 0; w < ADDR_WORDS; w++) begin
            spec_mem[w] = word_t'(w) + INIT_KEY;
        end

        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_count++;
        assert (!wb_valid && lq_empty && !lq_full) else begin
            error_count++;
            $display("outputs after reset are not idle");
        end

        // fill the load queue and then drop one more load
        for (int i = 0; i <= LQ_SIZE; i++) begin
            next_cycle();
            dispatch_load();
        end
        // a wrong index while full frees nothing
        next_cycle();
        rob_commit_valid = 1'b1;
        rob_commit_idx   = next_rob + rob_idx_t'(8);

        // mixed random run until everything drains
        while (issued_ops < NUM_OPS || rob_q.size() > 0) begin
            next_cycle();
            commit_head();
            fill_random_store();
            if (issued_ops < NUM_OPS) begin
                random_dispatch();
            end
        end
        next_cycle();
        check_count++;
        assert (lq_empty && !sq_full) else begin
            error_count++;
            $display("queues did not drain at the end of the run");
        end

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
logic/lsq_pkg.sv
logic/store_queue.sv
logic/load_queue.sv
logic/data_memory.sv
logic/lsq_top.sv
verif/lsq_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f verilog.f --top-module lsq_tb -o lsq_sim
./obj_dir/lsq_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
